//--- Makefile
TOP := rfdc_timing_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
	  echo "test failed"; \
	  exit 1; \
	fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- ctrlport_timer.sv
// per-board command timer with one timed command slot and collision rejection
`timescale 1ns/1ps

module ctrlport_timer (
  input  logic                            clk,
  input  logic                            rst_n_i,
  input  rfdc_timing_pkg::time_t          time_i,
  input  rfdc_timing_pkg::ctrlport_req_t  req_i,
  output rfdc_timing_pkg::ctrlport_resp_t resp_o,
  output rfdc_timing_pkg::ctrlport_req_t  fwd_req_o,
  input  rfdc_timing_pkg::ctrlport_resp_t fwd_resp_i
);

  import rfdc_timing_pkg::*;

  // --------------------------------------------------------------------------
  // state and storage
  // --------------------------------------------------------------------------

  typedef enum logic {
    IDLE,
    WAIT
  } timer_state_e;

  timer_state_e  state_q;
  ctrlport_req_t held_req;    // request being forwarded or waiting
  logic          req_valid;
  logic          due;
  logic          fwd_wr_q;
  logic          fwd_rd_q;
  logic          rej_ack_q;   // error response strobe

  assign req_valid = req_i.wr | req_i.rd;

  // held command is due once radio time catches up
  assign due = (time_i >= held_req.timestamp);

  // payload capture, only while the slot is free
  always_ff @(posedge clk) begin
    if (state_q == IDLE && req_valid) begin
      held_req <= req_i;
    end
  end

  // --------------------------------------------------------------------------
  // control FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q   <= IDLE;
      fwd_wr_q  <= 1'b0;
      fwd_rd_q  <= 1'b0;
      rej_ack_q <= 1'b0;
    end else begin
      // strobes last one cycle
      fwd_wr_q  <= 1'b0;
      fwd_rd_q  <= 1'b0;
      rej_ack_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (req_valid) begin
            if (req_i.has_time) begin
              // park it until its time comes
              state_q <= WAIT;
            end else begin
              fwd_wr_q <= req_i.wr;
              fwd_rd_q <= req_i.rd;
            end
          end
        end
        WAIT: begin
          // slot busy, anything new gets an error
          rej_ack_q <= req_valid;
          if (due) begin
            fwd_wr_q <= held_req.wr;
            fwd_rd_q <= held_req.rd;
            state_q  <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // outputs
  // --------------------------------------------------------------------------

  always_comb begin
    fwd_req_o    = held_req;
    fwd_req_o.wr = fwd_wr_q;
    fwd_req_o.rd = fwd_rd_q;
  end

  // rejection and forwarded ack never coincide
  always_comb begin
    resp_o.ack    = fwd_resp_i.ack | rej_ack_q;
    resp_o.status = rej_ack_q ? STS_CMDERR : fwd_resp_i.status;
    resp_o.data   = rej_ack_q ? '0 : fwd_resp_i.data;
  end

endmodule

//--- list.f
rfdc_timing_pkg.sv
ctrlport_timer.sv
rfdc_timing_regs.sv
nco_reset_sequencer.sv
rfdc_timing_control.sv
rfdc_timing_tb.sv

//--- nco_reset_sequencer.sv
// merge of per-board nco start strobes and nco done synchronizer
`timescale 1ns/1ps

module nco_reset_sequencer (
  input  logic                                   clk,
  input  logic                                   rst_n_i,
  input  logic [rfdc_timing_pkg::NUM_DBOARDS-1:0] nco_start_i,
  output logic                                   start_nco_reset_o,
  input  logic                                   nco_reset_done_i,
  output logic                                   nco_done_o
);

  import rfdc_timing_pkg::*;

  // --------------------------------------------------------------------------
  // start merge
  // --------------------------------------------------------------------------

  logic any_start;
  logic start_q;
  logic done_meta_q;   // first sync stage
  logic done_sync_q;   // second sync stage

  // simultaneous starts from several boards give one pulse
  always_comb begin
    any_start = 1'b0;
    for (int i = 0; i < NUM_DBOARDS; i++) begin
      any_start = any_start | nco_start_i[i];
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      start_q <= 1'b0;
    end else begin
      start_q <= any_start;
    end
  end

  assign start_nco_reset_o = start_q;

  // --------------------------------------------------------------------------
  // done synchronizer
  // --------------------------------------------------------------------------

  // done is a level from the converter, async to clk
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_meta_q <= 1'b0;
      done_sync_q <= 1'b0;
    end else begin
      done_meta_q <= nco_reset_done_i;
      done_sync_q <= done_meta_q;
    end
  end

  // shared by every register block
  assign nco_done_o = done_sync_q;

endmodule

//--- rfdc_timing_control.sv
// top level with per-board timer and register block plus shared nco sequencer
`timescale 1ns/1ps

module rfdc_timing_control (
  input  logic                             clk,
  input  logic                             rst_n_i,
  input  rfdc_timing_pkg::time_t           time_i,
  input  rfdc_timing_pkg::ctrlport_req_t  [rfdc_timing_pkg::NUM_DBOARDS-1:0] ctrl_req_i,
  output rfdc_timing_pkg::ctrlport_resp_t [rfdc_timing_pkg::NUM_DBOARDS-1:0] ctrl_resp_o,
  output logic                             start_nco_reset_o,
  input  logic                             nco_reset_done_i,
  output logic [rfdc_timing_pkg::NUM_DBOARDS-1:0] adc_reset_pulse_o,
  output logic [rfdc_timing_pkg::NUM_DBOARDS-1:0] dac_reset_pulse_o
);

  import rfdc_timing_pkg::*;

  // --------------------------------------------------------------------------
  // internal wiring
  // --------------------------------------------------------------------------

  // timer to register block
  ctrlport_req_t  [NUM_DBOARDS-1:0] fwd_req;
  ctrlport_resp_t [NUM_DBOARDS-1:0] fwd_resp;
  // register blocks to sequencer
  logic           [NUM_DBOARDS-1:0] nco_start;
  logic                             nco_done;

  // --------------------------------------------------------------------------
  // per-board path
  // --------------------------------------------------------------------------

  for (genvar db = 0; db < NUM_DBOARDS; db++) begin : gen_db

    // timed command handling
    ctrlport_timer ctrlport_timer_inst (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .time_i     (time_i),
      .req_i      (ctrl_req_i[db]),
      .resp_o     (ctrl_resp_o[db]),
      .fwd_req_o  (fwd_req[db]),
      .fwd_resp_i (fwd_resp[db])
    );

    // register decode and reset strobes
    rfdc_timing_regs rfdc_timing_regs_inst (
      .clk               (clk),
      .rst_n_i           (rst_n_i),
      .req_i             (fwd_req[db]),
      .resp_o            (fwd_resp[db]),
      .nco_done_i        (nco_done),
      .nco_start_o       (nco_start[db]),
      .adc_reset_pulse_o (adc_reset_pulse_o[db]),
      .dac_reset_pulse_o (dac_reset_pulse_o[db])
    );

  end

  // --------------------------------------------------------------------------
  // shared nco reset
  // --------------------------------------------------------------------------

  nco_reset_sequencer nco_reset_sequencer_inst (
    .clk               (clk),
    .rst_n_i           (rst_n_i),
    .nco_start_i       (nco_start),
    .start_nco_reset_o (start_nco_reset_o),
    .nco_reset_done_i  (nco_reset_done_i),
    .nco_done_o        (nco_done)
  );

endmodule

//--- rfdc_timing_pkg.sv
// board count, register map constants, status codes and control-port types
package rfdc_timing_pkg;

  // --------------------------------------------------------------------------
  // system size
  // --------------------------------------------------------------------------

  // daughterboards served by one timing block
  localparam int NUM_DBOARDS = 2;

  // --------------------------------------------------------------------------
  // basic widths
  // --------------------------------------------------------------------------

  // control-port word address
  typedef logic [19:0] ctrl_addr_t;
  // register data word
  typedef logic [31:0] ctrl_data_t;
  // response status code
  typedef logic [1:0]  ctrl_status_t;
  // radio time in clock ticks
  typedef logic [63:0] time_t;

  // --------------------------------------------------------------------------
  // register map
  // --------------------------------------------------------------------------

  // nco reset control
  localparam ctrl_addr_t NCO_RESET_REG     = 20'h00000;
  // adc and dac gearbox reset control
  localparam ctrl_addr_t GEARBOX_RESET_REG = 20'h00004;

  // nco reset register bits
  localparam int NCO_RESET_START = 0;  // write 1 to start
  localparam int NCO_RESET_DONE  = 1;  // read only

  // gearbox reset register bits, write-only strobes
  localparam int ADC_RESET = 0;
  localparam int DAC_RESET = 1;

  // response status values
  localparam ctrl_status_t STS_OKAY   = 2'd0;
  localparam ctrl_status_t STS_CMDERR = 2'd1;

  // --------------------------------------------------------------------------
  // control-port bundles
  // --------------------------------------------------------------------------

  // one-cycle request, wr and rd never high together
  typedef struct packed {
    logic       wr;
    logic       rd;
    ctrl_addr_t addr;
    ctrl_data_t data;
    logic       has_time;   // hold until timestamp
    time_t      timestamp;
  } ctrlport_req_t;

  // one-cycle response, ack qualifies status and data
  typedef struct packed {
    logic         ack;
    ctrl_status_t status;
    ctrl_data_t   data;
  } ctrlport_resp_t;

endpackage

//--- rfdc_timing_regs.sv
// per-board register block for nco reset and gearbox reset control
`timescale 1ns/1ps

module rfdc_timing_regs (
  input  logic                            clk,
  input  logic                            rst_n_i,
  input  rfdc_timing_pkg::ctrlport_req_t  req_i,
  output rfdc_timing_pkg::ctrlport_resp_t resp_o,
  input  logic                            nco_done_i,
  output logic                            nco_start_o,
  output logic                            adc_reset_pulse_o,
  output logic                            dac_reset_pulse_o
);

  import rfdc_timing_pkg::*;

  // --------------------------------------------------------------------------
  // address decode
  // --------------------------------------------------------------------------

  logic       hit_nco;
  logic       hit_gbx;
  logic       req_known;
  logic       ack_q;
  logic       nco_start_q;
  logic       adc_pulse_q;
  logic       dac_pulse_q;
  ctrl_data_t rd_data_q;

  assign hit_nco = (req_i.addr == NCO_RESET_REG);
  assign hit_gbx = (req_i.addr == GEARBOX_RESET_REG);

  // unknown offsets are silently dropped, no ack
  assign req_known = (req_i.wr | req_i.rd) & (hit_nco | hit_gbx);

  // --------------------------------------------------------------------------
  // ack and write strobes
  // --------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q       <= 1'b0;
      nco_start_q <= 1'b0;
      adc_pulse_q <= 1'b0;
      dac_pulse_q <= 1'b0;
    end else begin
      ack_q <= req_known;
      // strobes land in the ack cycle
      nco_start_q <= req_i.wr & hit_nco & req_i.data[NCO_RESET_START];
      adc_pulse_q <= req_i.wr & hit_gbx & req_i.data[ADC_RESET];
      dac_pulse_q <= req_i.wr & hit_gbx & req_i.data[DAC_RESET];
    end
  end

  // --------------------------------------------------------------------------
  // read data
  // --------------------------------------------------------------------------

  // only the done flag is readable, gearbox bits read back as zero
  always_ff @(posedge clk) begin
    rd_data_q <= '0;
    if (req_i.rd && hit_nco) begin
      rd_data_q[NCO_RESET_DONE] <= nco_done_i;
    end
  end

  // --------------------------------------------------------------------------
  // outputs
  // --------------------------------------------------------------------------

  always_comb begin
    resp_o.ack    = ack_q;
    // every decoded access succeeds
    resp_o.status = STS_OKAY;
    resp_o.data   = rd_data_q;
  end

  // one-cycle pulses straight to the converter
  assign adc_reset_pulse_o = adc_pulse_q;
  assign dac_reset_pulse_o = dac_pulse_q;

  // nco start goes through the shared sequencer
  assign nco_start_o = nco_start_q;

endmodule

//--- rfdc_timing_tb.sv
// directed testbench for the timing control block with pulse monitor and summary
`timescale 1ns/1ps

module rfdc_timing_tb;

  import rfdc_timing_pkg::*;

  logic                             clk = 1'b0;
  logic                             rst_n;
  logic                             nco_reset_done;
  logic                             start_nco_reset;
  logic           [NUM_DBOARDS-1:0] adc_pulse;
  logic           [NUM_DBOARDS-1:0] dac_pulse;
  time_t                            time_cnt = '0;
  ctrlport_req_t  [NUM_DBOARDS-1:0] ctrl_req;
  ctrlport_resp_t [NUM_DBOARDS-1:0] ctrl_resp;

  // pulses seen by the monitor and pulses the tests expect
  int adc_cnt [NUM_DBOARDS] = '{default: 0};
  int dac_cnt [NUM_DBOARDS] = '{default: 0};
  int exp_adc [NUM_DBOARDS] = '{default: 0};
  int exp_dac [NUM_DBOARDS] = '{default: 0};
  int start_cnt = 0;
  int exp_start = 0;
  int checks = 0;
  int errors = 0;

  rfdc_timing_control rfdc_timing_control_inst (
    .clk               (clk),
    .rst_n_i           (rst_n),
    .time_i            (time_cnt),
    .ctrl_req_i        (ctrl_req),
    .ctrl_resp_o       (ctrl_resp),
    .start_nco_reset_o (start_nco_reset),
    .nco_reset_done_i  (nco_reset_done),
    .adc_reset_pulse_o (adc_pulse),
    .dac_reset_pulse_o (dac_pulse)
  );

  always #5 clk = ~clk;

  // radio time, one tick per cycle, lands 1 ns after the edge
  always @(posedge clk) time_cnt <= #1 time_cnt + 64'd1;

  // count every strobe the DUT produces
  always @(posedge clk) begin
    if (rst_n) begin
      for (int i = 0; i < NUM_DBOARDS; i++) begin
        adc_cnt[i] <= adc_cnt[i] + int'(adc_pulse[i]);
        dac_cnt[i] <= dac_cnt[i] + int'(dac_pulse[i]);
      end
      start_cnt <= start_cnt + int'(start_nco_reset);
    end
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic expect_eq(string name, int got, int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic expect_true(logic cond, string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  // one-cycle request, returns in the cycle after it
  task automatic drive_req(int db, logic wr, ctrl_addr_t addr, ctrl_data_t data,
                           logic timed, time_t ts);
    ctrl_req[db].wr        = wr;
    ctrl_req[db].rd        = ~wr;
    ctrl_req[db].addr      = addr;
    ctrl_req[db].data      = data;
    ctrl_req[db].has_time  = timed;
    ctrl_req[db].timestamp = ts;
    tick();
    ctrl_req[db] = '0;
  endtask

  // lat counts cycles waited, 0 means ack in the current cycle
  task automatic wait_ack(int db, int limit, output logic got, output int lat);
    lat = 0;
    while (!ctrl_resp[db].ack && lat < limit) begin
      tick();
      lat++;
    end
    got = ctrl_resp[db].ack;
  endtask

  task automatic do_write(int db, ctrl_addr_t addr, ctrl_data_t data);
    logic got;
    int   lat;
    drive_req(db, 1'b1, addr, data, 1'b0, '0);
    wait_ack(db, 20, got, lat);
    expect_true(got, $sformatf("write to board %0d got no ack in 20 cycles", db));
    expect_eq($sformatf("ctrl_resp_o[%0d] write latency", db), lat, 1);
    expect_eq($sformatf("ctrl_resp_o[%0d].status", db), int'(ctrl_resp[db].status),
              int'(STS_OKAY));
  endtask

  task automatic do_read(int db, ctrl_addr_t addr, output ctrl_data_t data);
    logic got;
    int   lat;
    drive_req(db, 1'b0, addr, '0, 1'b0, '0);
    wait_ack(db, 20, got, lat);
    expect_true(got, $sformatf("read from board %0d got no ack in 20 cycles", db));
    expect_eq($sformatf("ctrl_resp_o[%0d].status", db), int'(ctrl_resp[db].status),
              int'(STS_OKAY));
    data = ctrl_resp[db].data;
  endtask

  // board must stay silent until radio time reaches ts
  task automatic hold_until(int db, time_t ts);
    int n;
    n = 0;
    while (time_cnt < ts && n < 40) begin
      expect_true(!ctrl_resp[db].ack && !adc_pulse[db] && !dac_pulse[db],
                  "ack or pulse appeared before the timestamp");
      tick();
      n++;
    end
    expect_true(time_cnt >= ts, "radio time did not reach the timestamp in 40 cycles");
  endtask

  task automatic expect_gearbox(int db, int bits);
    expect_eq($sformatf("adc_reset_pulse_o[%0d]", db), int'(adc_pulse[db]),
              (bits >> ADC_RESET) & 1);
    expect_eq($sformatf("dac_reset_pulse_o[%0d]", db), int'(dac_pulse[db]),
              (bits >> DAC_RESET) & 1);
    exp_adc[db] += (bits >> ADC_RESET) & 1;
    exp_dac[db] += (bits >> DAC_RESET) & 1;
  endtask

  task automatic check_pulse_counts();
    // let the last strobes reach the monitor
    tick();
    tick();
    for (int i = 0; i < NUM_DBOARDS; i++) begin
      expect_eq($sformatf("adc_reset_pulse_o[%0d] count", i), adc_cnt[i], exp_adc[i]);
      expect_eq($sformatf("dac_reset_pulse_o[%0d] count", i), dac_cnt[i], exp_dac[i]);
    end
    expect_eq("start_nco_reset_o count", start_cnt, exp_start);
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------

  task automatic test_gearbox();
    int         db;
    int         bits;
    ctrl_data_t rdata;
    db   = int'($urandom_range(NUM_DBOARDS - 1, 0));
    bits = int'($urandom_range(3, 1));
    do_write(db, GEARBOX_RESET_REG, ctrl_data_t'(bits));
    expect_gearbox(db, bits);
    do_read(db, GEARBOX_RESET_REG, rdata);
    expect_eq($sformatf("ctrl_resp_o[%0d].data", db), int'(rdata), 0);
    check_pulse_counts();
  endtask

  task automatic test_nco_start();
    int   db;
    logic got;
    int   lat;
    db = int'($urandom_range(NUM_DBOARDS - 1, 0));
    do_write(db, NCO_RESET_REG, ctrl_data_t'(1 << NCO_RESET_START));
    tick();
    expect_eq("start_nco_reset_o", int'(start_nco_reset), 1);
    exp_start++;
    // every board at once still gives a single pulse
    for (int i = 0; i < NUM_DBOARDS; i++) begin
      ctrl_req[i].wr   = 1'b1;
      ctrl_req[i].addr = NCO_RESET_REG;
      ctrl_req[i].data = ctrl_data_t'(1 << NCO_RESET_START);
    end
    tick();
    ctrl_req = '0;
    wait_ack(0, 20, got, lat);
    expect_true(got, "shared nco start write got no ack in 20 cycles");
    tick();
    expect_eq("start_nco_reset_o", int'(start_nco_reset), 1);
    exp_start++;
    do_write(db, NCO_RESET_REG, '0);
    check_pulse_counts();
  endtask

  task automatic test_nco_done();
    int         db;
    ctrl_data_t rdata;
    db = int'($urandom_range(NUM_DBOARDS - 1, 0));
    do_read(db, NCO_RESET_REG, rdata);
    expect_eq($sformatf("ctrl_resp_o[%0d].data", db), int'(rdata), 0);
    nco_reset_done = 1'b1;
    repeat (3) tick();
    do_read(db, NCO_RESET_REG, rdata);
    expect_eq($sformatf("ctrl_resp_o[%0d].data", db), int'(rdata), 1 << NCO_RESET_DONE);
    nco_reset_done = 1'b0;
    repeat (3) tick();
  endtask

  task automatic test_timed_write();
    int    db;
    int    bits;
    logic  got;
    int    lat;
    time_t ts;
    db   = int'($urandom_range(NUM_DBOARDS - 1, 0));
    bits = int'($urandom_range(3, 1));
    ts   = time_cnt + 64'd30;
    drive_req(db, 1'b1, GEARBOX_RESET_REG, ctrl_data_t'(bits), 1'b1, ts);
    hold_until(db, ts);
    wait_ack(db, 3, got, lat);
    expect_true(got, "timed write got no ack within 3 cycles of its timestamp");
    expect_gearbox(db, bits);
    // stale timestamp runs one cycle later than an immediate write
    ts = time_cnt - 64'd5;
    drive_req(db, 1'b1, GEARBOX_RESET_REG, ctrl_data_t'(bits), 1'b1, ts);
    wait_ack(db, 20, got, lat);
    expect_true(got, "write with past timestamp got no ack in 20 cycles");
    expect_eq($sformatf("ctrl_resp_o[%0d].ack past timestamp latency", db), lat, 2);
    expect_gearbox(db, bits);
    check_pulse_counts();
  endtask

  task automatic test_collision();
    int    db;
    int    other;
    int    bits;
    logic  got;
    int    lat;
    time_t ts;
    db    = int'($urandom_range(NUM_DBOARDS - 1, 0));
    other = (db + 1) % NUM_DBOARDS;
    // held bits never match the colliding write of both bits
    bits  = int'($urandom_range(2, 1));
    ts    = time_cnt + 64'd30;
    drive_req(db, 1'b1, GEARBOX_RESET_REG, ctrl_data_t'(bits), 1'b1, ts);
    drive_req(db, 1'b1, GEARBOX_RESET_REG, ctrl_data_t'(3), 1'b0, '0);
    wait_ack(db, 20, got, lat);
    expect_true(got, "colliding request got no ack in 20 cycles");
    expect_eq($sformatf("ctrl_resp_o[%0d].ack reject latency", db), lat, 0);
    expect_eq($sformatf("ctrl_resp_o[%0d].status", db), int'(ctrl_resp[db].status),
              int'(STS_CMDERR));
    expect_eq($sformatf("ctrl_resp_o[%0d].data", db), int'(ctrl_resp[db].data), 0);
    // other board runs as usual
    do_write(other, GEARBOX_RESET_REG, ctrl_data_t'(3));
    expect_gearbox(other, 3);
    hold_until(db, ts);
    wait_ack(db, 3, got, lat);
    expect_true(got, "held write got no ack within 3 cycles of its timestamp");
    expect_gearbox(db, bits);
    check_pulse_counts();
  endtask

  task automatic test_unknown_addr();
    int   db;
    logic got;
    int   lat;
    db = int'($urandom_range(NUM_DBOARDS - 1, 0));
    drive_req(db, 1'b1, 20'h00008, ctrl_data_t'(3), 1'b0, '0);
    wait_ack(db, 10, got, lat);
    expect_true(!got, "write to offset 0x08 was acknowledged");
    drive_req(db, 1'b0, 20'h00008, '0, 1'b0, '0);
    wait_ack(db, 10, got, lat);
    expect_true(!got, "read from offset 0x08 was acknowledged");
    check_pulse_counts();
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------

  initial begin
    rst_n          = 1'b0;
    nco_reset_done = 1'b0;
    ctrl_req       = '0;
    void'($urandom(32'h52e2_72ef));
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    tick();
    test_gearbox();
    test_nco_start();
    test_nco_done();
    test_timed_write();
    test_collision();
    test_unknown_addr();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
